/* verilog/wb_xbar_config.svh */
`ifndef WB_XBAR_CONFIG_SVH
`define WB_XBAR_CONFIG_SVH

// Bus widths
`define WB_ADDR_W 32
`define WB_DATA_W 32

// Port counts
`define WB_N_MASTERS 3
`define WB_N_SLAVES 4

// Address map
// Windows are inclusive at both ends
`define WB_S0_BASE 32'h0000_0000
`define WB_S0_LIMIT 32'h0000_0FFF

`define WB_S1_BASE 32'h0000_1000
`define WB_S1_LIMIT 32'h0000_1FFF

`define WB_S2_BASE 32'h0000_2000
`define WB_S2_LIMIT 32'h0000_2FFF

`define WB_S3_BASE 32'h0000_3000
`define WB_S3_LIMIT 32'h0000_3FFF

// Decode-error target sits right after the real slaves
`define WB_ERR_TARGET 4

`endif

/* verilog/wb_xbar_pkg.sv */
`default_nettype none

`include "wb_xbar_config.svh"

package wb_xbar_pkg;

	// Bus payload types
	typedef logic [`WB_ADDR_W-1:0] wb_addr_t;
	typedef logic [`WB_DATA_W-1:0] wb_data_t;

	// One select bit per data byte
	typedef logic [`WB_DATA_W/8-1:0] wb_sel_t;

	// Master number, wide enough for three masters
	typedef logic [1:0] master_id_t;

	// Target number
	// Targets 0 to 3 are slaves, 4 is the decode-error target
	typedef logic [2:0] target_id_t;

	// Request or grant vector, one bit per master
	typedef logic [`WB_N_MASTERS-1:0] master_vec_t;

	// Marks a master port with no access in flight
	localparam target_id_t TGT_NONE = 3'd7;

endpackage

`default_nettype wire

/* verilog/wb_rr_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wb_xbar_config.svh"

module wb_rr_arbiter (
	input wire logic clk,
	input wire logic rstn,
	input wire wb_xbar_pkg::master_vec_t req_i,
	output logic gnt_o,
	output wb_xbar_pkg::master_id_t gnt_id_o
);
	import wb_xbar_pkg::*;

	localparam int N = `WB_N_MASTERS;

	typedef enum logic {
		ARB_IDLE,
		ARB_HOLD
	} arb_state_t;

	arb_state_t state;

	// Currently granted master, one-hot
	master_vec_t gnt_vec;
	// Winner of the last arbitration, kept for rotation
	master_vec_t last_gnt;
	// Set for every master above the last winner
	master_vec_t above_last;
	master_vec_t unmasked_gnt;
	master_vec_t masked_gnt;
	master_vec_t next_gnt;
	master_id_t next_id;

	// Thermometer mask of positions above the last winner
	always_comb begin
		above_last[0] = 1'b0;
		for (int i = 1; i < N; i++) begin
			above_last[i] = above_last[i-1] | last_gnt[i-1];
		end
	end

	// Fixed priority over all requests and over those above the last winner
	// Lowest index wins in both
	always_comb begin
		unmasked_gnt = '0;
		masked_gnt = '0;
		for (int i = N - 1; i >= 0; i--) begin
			if (req_i[i]) begin
				unmasked_gnt = '0;
				unmasked_gnt[i] = 1'b1;
			end
			if (req_i[i] && above_last[i]) begin
				masked_gnt = '0;
				masked_gnt[i] = 1'b1;
			end
		end
	end

	// Masked pick first so the grant rotates
	assign next_gnt = (|masked_gnt) ? masked_gnt : unmasked_gnt;

	// One-hot to index
	always_comb begin
		next_id = '0;
		for (int i = 0; i < N; i++) begin
			if (next_gnt[i]) begin
				next_id = master_id_t'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= ARB_IDLE;
			gnt_vec <= '0;
			last_gnt <= '0;
			gnt_id_o <= '0;
		end else begin
			case (state)
				ARB_IDLE: begin
					// Register a winner as soon as anyone asks
					if (|req_i) begin
						state <= ARB_HOLD;
						gnt_vec <= next_gnt;
						last_gnt <= next_gnt;
						gnt_id_o <= next_id;
					end
				end
				ARB_HOLD: begin
					// Hold until the winner lets go of its request
					if ((gnt_vec & req_i) == '0) begin
						state <= ARB_IDLE;
						gnt_vec <= '0;
					end
				end
				default: begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	assign gnt_o = (state == ARB_HOLD);

endmodule

`default_nettype wire

/* verilog/wb_master_port.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wb_xbar_config.svh"

module wb_master_port #(
	parameter wb_xbar_pkg::master_id_t MASTER_ID = '0
) (
	input wire logic clk,
	input wire logic rstn,
	input wire logic cyc_i,
	input wire logic stb_i,
	input wire wb_xbar_pkg::wb_addr_t adr_i,
	output logic [`WB_N_SLAVES:0] req_o,
	input wire logic [`WB_N_SLAVES:0] tgt_gnt_i,
	input wire wb_xbar_pkg::master_id_t tgt_gnt_id_i [`WB_N_SLAVES+1],
	input wire logic [`WB_N_SLAVES:0] tgt_ack_i,
	input wire logic [`WB_N_SLAVES:0] tgt_err_i,
	input wire wb_xbar_pkg::wb_data_t tgt_dat_i [`WB_N_SLAVES+1],
	output logic ack_o,
	output logic err_o,
	output wb_xbar_pkg::wb_data_t dat_o
);
	import wb_xbar_pkg::*;

	localparam int N_TGT = `WB_N_SLAVES + 1;

	// Address windows of the real slaves
	localparam wb_addr_t WIN_BASE [`WB_N_SLAVES] = '{
		`WB_S0_BASE, `WB_S1_BASE, `WB_S2_BASE, `WB_S3_BASE
	};
	localparam wb_addr_t WIN_LIMIT [`WB_N_SLAVES] = '{
		`WB_S0_LIMIT, `WB_S1_LIMIT, `WB_S2_LIMIT, `WB_S3_LIMIT
	};

	// Target of the access in flight
	// TGT_NONE while idle
	target_id_t tgt_sel;

	// Window lookup, misses land on the error target
	function automatic target_id_t addr_to_target(input wb_addr_t addr);
		target_id_t tgt;
		tgt = target_id_t'(`WB_ERR_TARGET);
		for (int s = `WB_N_SLAVES - 1; s >= 0; s--) begin
			if (addr >= WIN_BASE[s] && addr <= WIN_LIMIT[s]) begin
				tgt = target_id_t'(s);
			end
		end
		return tgt;
	endfunction

	always_ff @(posedge clk) begin
		if (!rstn) begin
			tgt_sel <= TGT_NONE;
		end else if (tgt_sel == TGT_NONE) begin
			// New access, latch its target
			if (cyc_i && stb_i) begin
				tgt_sel <= addr_to_target(adr_i);
			end
		end else if (ack_o || err_o) begin
			// Response delivered, back to idle
			tgt_sel <= TGT_NONE;
		end
	end

	// One request line per target, high while the access is pending
	always_comb begin
		for (int t = 0; t < N_TGT; t++) begin
			req_o[t] = (tgt_sel == target_id_t'(t));
		end
	end

	// Response return
	// Only the selected target, and only while it grants this master
	always_comb begin
		ack_o = 1'b0;
		err_o = 1'b0;
		dat_o = '0;
		for (int t = 0; t < N_TGT; t++) begin
			if (tgt_sel == target_id_t'(t) && tgt_gnt_i[t] &&
					tgt_gnt_id_i[t] == MASTER_ID) begin
				ack_o = tgt_ack_i[t];
				err_o = tgt_err_i[t];
				dat_o = tgt_dat_i[t];
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/wb_slave_port.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wb_xbar_config.svh"

module wb_slave_port (
	input wire logic clk,
	input wire logic rstn,
	input wire wb_xbar_pkg::master_vec_t req_i,
	input wire logic cyc_i [`WB_N_MASTERS],
	input wire logic stb_i [`WB_N_MASTERS],
	input wire logic we_i [`WB_N_MASTERS],
	input wire wb_xbar_pkg::wb_addr_t adr_i [`WB_N_MASTERS],
	input wire wb_xbar_pkg::wb_sel_t sel_i [`WB_N_MASTERS],
	input wire wb_xbar_pkg::wb_data_t dat_i [`WB_N_MASTERS],
	output logic gnt_o,
	output wb_xbar_pkg::master_id_t gnt_id_o,
	output logic cyc_o,
	output logic stb_o,
	output logic we_o,
	output wb_xbar_pkg::wb_addr_t adr_o,
	output wb_xbar_pkg::wb_sel_t sel_o,
	output wb_xbar_pkg::wb_data_t dat_o
);
	import wb_xbar_pkg::*;

	localparam int N = `WB_N_MASTERS;

	// Round-robin owner of this target
	wb_rr_arbiter u_arb (
		.clk(clk),
		.rstn(rstn),
		.req_i(req_i),
		.gnt_o(gnt_o),
		.gnt_id_o(gnt_id_o)
	);

	// Request steering
	// Bus idles at zero when nobody holds the grant
	always_comb begin
		cyc_o = 1'b0;
		stb_o = 1'b0;
		we_o = 1'b0;
		adr_o = '0;
		sel_o = '0;
		dat_o = '0;
		if (gnt_o) begin
			for (int m = 0; m < N; m++) begin
				if (gnt_id_o == master_id_t'(m)) begin
					cyc_o = cyc_i[m];
					stb_o = stb_i[m];
					we_o = we_i[m];
					adr_o = adr_i[m];
					sel_o = sel_i[m];
					dat_o = dat_i[m];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/wb_decode_err_target.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_decode_err_target (
	input wire logic clk,
	input wire logic rstn,
	input wire logic cyc_i,
	input wire logic stb_i,
	output logic ack_o,
	output logic err_o,
	output wb_xbar_pkg::wb_data_t dat_o
);

	// High for the one cycle ERR is driven
	logic err_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			// Answer one cycle after the strobe, then drop
			// so a held strobe gets a single pulse
			err_q <= cyc_i && stb_i && !err_q;
		end
	end

	assign err_o = err_q;

	// Never acks, never returns data
	assign ack_o = 1'b0;
	assign dat_o = '0;

endmodule

`default_nettype wire

/* verilog/wb_xbar_3x4.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wb_xbar_config.svh"

module wb_xbar_3x4 (
	input wire logic clk,
	input wire logic rstn,
	input wire logic m_cyc_i [`WB_N_MASTERS],
	input wire logic m_stb_i [`WB_N_MASTERS],
	input wire logic m_we_i [`WB_N_MASTERS],
	input wire wb_xbar_pkg::wb_addr_t m_adr_i [`WB_N_MASTERS],
	input wire wb_xbar_pkg::wb_sel_t m_sel_i [`WB_N_MASTERS],
	input wire wb_xbar_pkg::wb_data_t m_dat_i [`WB_N_MASTERS],
	output wire logic m_ack_o [`WB_N_MASTERS],
	output wire logic m_err_o [`WB_N_MASTERS],
	output wire wb_xbar_pkg::wb_data_t m_dat_o [`WB_N_MASTERS],
	output wire logic s_cyc_o [`WB_N_SLAVES],
	output wire logic s_stb_o [`WB_N_SLAVES],
	output wire logic s_we_o [`WB_N_SLAVES],
	output wire wb_xbar_pkg::wb_addr_t s_adr_o [`WB_N_SLAVES],
	output wire wb_xbar_pkg::wb_sel_t s_sel_o [`WB_N_SLAVES],
	output wire wb_xbar_pkg::wb_data_t s_dat_o [`WB_N_SLAVES],
	input wire logic s_ack_i [`WB_N_SLAVES],
	input wire logic s_err_i [`WB_N_SLAVES],
	input wire wb_xbar_pkg::wb_data_t s_dat_i [`WB_N_SLAVES]
);
	import wb_xbar_pkg::*;

	localparam int N_MST = `WB_N_MASTERS;
	localparam int N_SLV = `WB_N_SLAVES;
	localparam int N_TGT = `WB_N_SLAVES + 1;

	// Request bits as each master port drives them, one per target
	wire logic [`WB_N_SLAVES:0] mst_req [N_MST];
	// Same bits regrouped per target
	wire master_vec_t tgt_req [N_TGT];

	// Grant state of every target
	wire logic [`WB_N_SLAVES:0] tgt_gnt;
	wire master_id_t tgt_gnt_id [N_TGT];

	// Responses of all five targets, error target last
	wire logic [`WB_N_SLAVES:0] tgt_ack;
	wire logic [`WB_N_SLAVES:0] tgt_err;
	wire wb_data_t tgt_rdat [N_TGT];

	// Steered request of every target
	wire logic tgt_cyc [N_TGT];
	wire logic tgt_stb [N_TGT];
	wire logic tgt_we [N_TGT];
	wire wb_addr_t tgt_adr [N_TGT];
	wire wb_sel_t tgt_sel [N_TGT];
	wire wb_data_t tgt_wdat [N_TGT];

	genvar m, t;

	// Master side decode and response return
	for (m = 0; m < N_MST; m++) begin : g_mst
		wb_master_port #(
			.MASTER_ID(master_id_t'(m))
		) u_mport (
			.clk(clk),
			.rstn(rstn),
			.cyc_i(m_cyc_i[m]),
			.stb_i(m_stb_i[m]),
			.adr_i(m_adr_i[m]),
			.req_o(mst_req[m]),
			.tgt_gnt_i(tgt_gnt),
			.tgt_gnt_id_i(tgt_gnt_id),
			.tgt_ack_i(tgt_ack),
			.tgt_err_i(tgt_err),
			.tgt_dat_i(tgt_rdat),
			.ack_o(m_ack_o[m]),
			.err_o(m_err_o[m]),
			.dat_o(m_dat_o[m])
		);
	end

	// Transpose requests from per-master to per-target
	for (t = 0; t < N_TGT; t++) begin : g_req
		for (m = 0; m < N_MST; m++) begin : g_bit
			assign tgt_req[t][m] = mst_req[m][t];
		end
	end

	// Target side arbitration and request steering
	for (t = 0; t < N_TGT; t++) begin : g_tgt
		wb_slave_port u_sport (
			.clk(clk),
			.rstn(rstn),
			.req_i(tgt_req[t]),
			.cyc_i(m_cyc_i),
			.stb_i(m_stb_i),
			.we_i(m_we_i),
			.adr_i(m_adr_i),
			.sel_i(m_sel_i),
			.dat_i(m_dat_i),
			.gnt_o(tgt_gnt[t]),
			.gnt_id_o(tgt_gnt_id[t]),
			.cyc_o(tgt_cyc[t]),
			.stb_o(tgt_stb[t]),
			.we_o(tgt_we[t]),
			.adr_o(tgt_adr[t]),
			.sel_o(tgt_sel[t]),
			.dat_o(tgt_wdat[t])
		);
	end

	// Real slaves on the external pins
	for (t = 0; t < N_SLV; t++) begin : g_slv_io
		assign s_cyc_o[t] = tgt_cyc[t];
		assign s_stb_o[t] = tgt_stb[t];
		assign s_we_o[t] = tgt_we[t];
		assign s_adr_o[t] = tgt_adr[t];
		assign s_sel_o[t] = tgt_sel[t];
		assign s_dat_o[t] = tgt_wdat[t];
		assign tgt_ack[t] = s_ack_i[t];
		assign tgt_err[t] = s_err_i[t];
		assign tgt_rdat[t] = s_dat_i[t];
	end

	// Catches every address outside the map
	wb_decode_err_target u_err_tgt (
		.clk(clk),
		.rstn(rstn),
		.cyc_i(tgt_cyc[`WB_ERR_TARGET]),
		.stb_i(tgt_stb[`WB_ERR_TARGET]),
		.ack_o(tgt_ack[`WB_ERR_TARGET]),
		.err_o(tgt_err[`WB_ERR_TARGET]),
		.dat_o(tgt_rdat[`WB_ERR_TARGET])
	);

endmodule

`default_nettype wire

/* verif/tb_wb_xbar.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wb_xbar_config.svh"

module tb_wb_xbar;
	import wb_xbar_pkg::*;

	localparam int N_MST = `WB_N_MASTERS;
	localparam int N_SLV = `WB_N_SLAVES;
	localparam int RESET_CYCLES = 8;
	localparam int CYCLES_PER_VEC = 100;
	localparam int MAX_VEC = 64;

	logic clk = 1'b0;
	logic rstn = 1'b0;

	// Master side driven by the test sequence
	logic m_cyc_i [N_MST] = '{default: 1'b0};
	logic m_stb_i [N_MST] = '{default: 1'b0};
	logic m_we_i [N_MST] = '{default: 1'b0};
	wb_addr_t m_adr_i [N_MST] = '{default: '0};
	wb_sel_t m_sel_i [N_MST] = '{default: '0};
	wb_data_t m_dat_i [N_MST] = '{default: '0};
	logic m_ack_o [N_MST];
	logic m_err_o [N_MST];
	wb_data_t m_dat_o [N_MST];

	// Slave side answered by the memory models
	logic s_cyc_o [N_SLV];
	logic s_stb_o [N_SLV];
	logic s_we_o [N_SLV];
	wb_addr_t s_adr_o [N_SLV];
	wb_sel_t s_sel_o [N_SLV];
	wb_data_t s_dat_o [N_SLV];
	logic s_ack_i [N_SLV] = '{default: 1'b0};
	logic s_err_i [N_SLV] = '{default: 1'b0};
	wb_data_t s_dat_i [N_SLV] = '{default: '0};

	// Memory model state with one 4 KB window per slave
	wb_data_t mem [N_SLV][1024];
	logic busy [N_SLV];
	logic [1:0] wait_left [N_SLV];
	int seed = 32'h4a0c50d7;

	// Vectors loaded from the data file
	logic vec_loaded = 1'b0;
	int n_vec = 0;
	int n_done = 0;
	int vec_group [MAX_VEC];
	int vec_master [MAX_VEC];
	logic vec_we [MAX_VEC];
	wb_addr_t vec_addr [MAX_VEC];
	wb_data_t vec_wdata [MAX_VEC];
	wb_sel_t vec_sel [MAX_VEC];
	wb_data_t vec_rdata [MAX_VEC];
	logic vec_err [MAX_VEC];

	wb_xbar_3x4 u_dut (.*);

	initial begin
		forever #50 clk = ~clk;
	end

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_data(input wb_data_t actual, input wb_data_t expected,
			input string what);
		if (actual !== expected) begin
			$display("FAILED %0t: %s is %h, expected %h", $time, what, actual, expected);
			abort_run();
		end
	endtask

	task automatic check_err(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			$display("FAILED %0t: %s is %b, expected %b", $time, what, actual, expected);
			abort_run();
		end
	endtask

	// Byte lanes with sel set take the new data
	function automatic wb_data_t merge_bytes(input wb_data_t old_w, input wb_data_t new_w,
			input wb_sel_t sel);
		wb_data_t res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

	// Slave number from the 4 KB address map or -1 when unmapped
	function automatic int slave_of_addr(input wb_addr_t a);
		if (a <= 32'h0000_3FFF) begin
			return int'(a[13:12]);
		end
		return -1;
	endfunction

	// A strobed slave must carry the request of one pending master aimed at its window
	task automatic match_slave_request(input int s);
		int hit;
		hit = -1;
		for (int m = 0; m < N_MST; m++) begin
			if (m_cyc_i[m] && m_stb_i[m] && slave_of_addr(m_adr_i[m]) == s &&
					m_adr_i[m] == s_adr_o[s]) begin
				hit = m;
			end
		end
		if (hit < 0) begin
			$display("Slave %0d strobed at %h with no master pending there", s, s_adr_o[s]);
			abort_run();
		end
		check_data(s_dat_o[s], m_dat_i[hit], $sformatf("slave %0d write data", s));
		check_data(wb_data_t'(s_sel_o[s]), wb_data_t'(m_sel_i[hit]),
			$sformatf("slave %0d byte selects", s));
		check_data(wb_data_t'(s_we_o[s]), wb_data_t'(m_we_i[hit]),
			$sformatf("slave %0d write enable", s));
	endtask

	// Does the memory access and raises ACK for one cycle
	task automatic serve_access(input int s);
		logic [9:0] idx;
		idx = s_adr_o[s][11:2];
		if (s_we_o[s]) begin
			mem[s][idx] = merge_bytes(mem[s][idx], s_dat_o[s], s_sel_o[s]);
		end else begin
			s_dat_i[s] <= mem[s][idx];
		end
		s_ack_i[s] <= 1'b1;
	endtask

	// Slave memory models with 0 to 3 random wait states
	always @(posedge clk) begin
		logic [1:0] n_wait;
		for (int s = 0; s < N_SLV; s++) begin
			if (!rstn) begin
				for (int w = 0; w < 1024; w++) begin
					mem[s][w] = '0;
				end
				s_ack_i[s] <= 1'b0;
				s_dat_i[s] <= '0;
				busy[s] <= 1'b0;
				wait_left[s] <= 2'd0;
			end else if (s_ack_i[s]) begin
				// ACK lasts exactly one cycle
				s_ack_i[s] <= 1'b0;
				s_dat_i[s] <= '0;
				busy[s] <= 1'b0;
			end else if (s_cyc_o[s] && s_stb_o[s]) begin
				match_slave_request(s);
				if (!busy[s]) begin
					// Wait states drawn once per access
					// With none the ACK follows the first strobed cycle
					n_wait = 2'($random(seed));
					if (n_wait == 2'd0) begin
						serve_access(s);
					end else begin
						busy[s] <= 1'b1;
						wait_left[s] <= n_wait - 2'd1;
					end
				end else if (wait_left[s] == 2'd0) begin
					serve_access(s);
				end else begin
					wait_left[s] <= wait_left[s] - 2'd1;
				end
			end
		end
	end

	// One master access from raising the strobe to checking the response
	task automatic run_access(input int v);
		int m;
		logic got_ack;
		logic got_err;
		wb_data_t got_dat;
		m = vec_master[v];
		@(posedge clk);
		m_cyc_i[m] <= 1'b1;
		m_stb_i[m] <= 1'b1;
		m_we_i[m] <= vec_we[v];
		m_adr_i[m] <= vec_addr[v];
		m_sel_i[m] <= vec_sel[v];
		m_dat_i[m] <= vec_wdata[v];
		// Response is sampled mid-cycle
		@(negedge clk);
		while (!(m_ack_o[m] || m_err_o[m])) begin
			@(negedge clk);
		end
		got_ack = m_ack_o[m];
		got_err = m_err_o[m];
		got_dat = m_dat_o[m];
		// Strobe drops in the cycle after the response
		@(posedge clk);
		m_cyc_i[m] <= 1'b0;
		m_stb_i[m] <= 1'b0;
		check_err(got_err, vec_err[v], $sformatf("m_err_o of vector %0d", v));
		check_err(got_ack, !vec_err[v], $sformatf("m_ack_o of vector %0d", v));
		if (!vec_we[v] || vec_err[v]) begin
			check_data(got_dat, vec_rdata[v], $sformatf("m_dat_o of vector %0d", v));
		end
		n_done++;
	endtask

	// Allows a fixed budget per vector on top of reset
	initial begin
		wait (vec_loaded);
		repeat (RESET_CYCLES + CYCLES_PER_VEC * n_vec) @(posedge clk);
		$display("Timeout with %0d of %0d transactions done", n_done, n_vec);
		abort_run();
	end

	initial begin
		int fd;
		int code;
		int first;
		int v;
		string line;
		int g;
		int m;
		logic we;
		wb_addr_t a;
		wb_data_t d;
		wb_sel_t sel;
		wb_data_t r;
		logic e;

		fd = $fopen("verif/wb_xbar_testdata.txt", "r");
		if (fd == 0) begin
			$display("Cannot open verif/wb_xbar_testdata.txt");
			abort_run();
		end
		// Comment lines fail the scan and are skipped
		while (!$feof(fd) && n_vec < MAX_VEC) begin
			code = $fgets(line, fd);
			if (code > 0 && $sscanf(line, "%h %h %h %h %h %h %h %h",
					g, m, we, a, d, sel, r, e) == 8) begin
				if (m >= N_MST) begin
					$display("Vector %0d names master %0d, which does not exist", n_vec, m);
					abort_run();
				end
				vec_group[n_vec] = g;
				vec_master[n_vec] = m;
				vec_we[n_vec] = we;
				vec_addr[n_vec] = a;
				vec_wdata[n_vec] = d;
				vec_sel[n_vec] = sel;
				vec_rdata[n_vec] = r;
				vec_err[n_vec] = e;
				n_vec++;
			end
		end
		$fclose(fd);
		if (n_vec == 0) begin
			$display("The test data file holds no vectors");
			abort_run();
		end
		vec_loaded = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk);
		rstn <= 1'b1;

		// Bus must be quiet right after reset
		@(negedge clk);
		for (int s = 0; s < N_SLV; s++) begin
			check_err(s_cyc_o[s], 1'b0, $sformatf("s_cyc_o[%0d] after reset", s));
			check_err(s_stb_o[s], 1'b0, $sformatf("s_stb_o[%0d] after reset", s));
		end
		for (int i = 0; i < N_MST; i++) begin
			check_err(m_ack_o[i], 1'b0, $sformatf("m_ack_o[%0d] after reset", i));
			check_err(m_err_o[i], 1'b0, $sformatf("m_err_o[%0d] after reset", i));
		end

		// Each group runs its masters together and finishes before the next
		v = 0;
		while (v < n_vec) begin
			first = v;
			while (v < n_vec && vec_group[v] == vec_group[first]) begin
				v++;
			end
			for (int i = first; i < v; i++) begin
				automatic int k = i;
				fork
					run_access(k);
				join_none
			end
			wait fork;
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/wb_xbar_testdata.txt */
// Columns are group, master, we, addr, wdata, sel, expected rdata, expected err (all hex)
// Lines of one group run together, one line per master
01 0 1 00000010 a0a0a0a0 f 00000000 0
01 1 1 00001020 b1b1b1b1 f 00000000 0
01 2 1 00002030 c2c2c2c2 f 00000000 0
02 0 1 00001040 0a0b0c0d f 00000000 0
02 1 1 00002050 1a1b1c1d f 00000000 0
02 2 1 00003060 2a2b2c2d f 00000000 0
03 0 1 00002070 deadbeef f 00000000 0
03 1 1 00003080 cafef00d f 00000000 0
03 2 1 00000010 000000ff 1 00000000 0
04 0 1 00003060 77660000 c 00000000 0
04 1 1 00000090 12345678 f 00000000 0
04 2 1 00001020 0000ab00 2 00000000 0
05 0 0 00000010 00000000 f a0a0a0ff 0
05 1 0 00001040 00000000 f 0a0b0c0d 0
05 2 0 00002070 00000000 f deadbeef 0
06 0 0 00001020 00000000 f b1b1abb1 0
06 1 0 00002030 00000000 f c2c2c2c2 0
06 2 0 00003080 00000000 f cafef00d 0
07 0 0 00002050 00000000 f 1a1b1c1d 0
07 1 0 00003060 00000000 f 77662c2d 0
07 2 0 00000090 00000000 f 12345678 0
08 0 0 00003ffc 00000000 f 00000000 0
08 1 0 00000ffc 00000000 f 00000000 0
08 2 0 00001020 00000000 f b1b1abb1 0
09 0 0 00004000 00000000 f 00000000 1
09 1 1 80000000 5a5a5a5a f 00000000 1
09 2 0 fffffffc 00000000 f 00000000 1
0a 0 1 00002100 11111111 f 00000000 0
0a 1 1 00002104 22222222 f 00000000 0
0a 2 1 00002108 33333333 f 00000000 0
0b 0 0 00002100 00000000 f 11111111 0
0b 1 0 00002104 00000000 f 22222222 0
0b 2 0 00002108 00000000 f 33333333 0

/* files.f */
+incdir+verilog
verilog/wb_xbar_pkg.sv
verilog/wb_rr_arbiter.sv
verilog/wb_master_port.sv
verilog/wb_slave_port.sv
verilog/wb_decode_err_target.sv
verilog/wb_xbar_3x4.sv
verif/tb_wb_xbar.sv

/* Makefile */
.PHONY: sim clean

# Build and run the testbench; $fatal makes the binary exit non-zero
sim:
	verilator --binary --timing --top-module tb_wb_xbar -f files.f
	./obj_dir/Vtb_wb_xbar

clean:
	rm -rf obj_dir
